// ==== project.f ====
colmix_pkg.sv
layer_prio.sv
pal_ram.sv
pal_cpu_port.sv
video_out.sv
colmix_top.sv
tb_colmix.sv

// ==== Makefile ====
# Verilator build and run of the colour mixer testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_colmix
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_colmix.sv ====
// testbench for the colour mixer
// fills the palette over the req/ack port, checks read-back and handshake timing,
// then drives random layer pixels on pxl_cen and compares rgb and blanks with a model
`timescale 1ns/100ps
`default_nettype none

module tb_colmix;
    import colmix_pkg::*;

    localparam logic [31:0] seed        = 32'ha3ca_c741;
    localparam int          hs_timeout  = 16;
    localparam int          cen_timeout = 8;
    localparam int          mode_mix    = 0;
    localparam int          mode_shadow = 1;
    localparam int          mode_gate   = 2;

    logic                clk;
    logic                arst_n;
    logic                pxl_cen;
    logic                video_en;
    logic [n_layers-1:0] gfx_en;
    logic [char_w-1:0]   char_pxl;
    logic [scr_w-1:0]    scr1_pxl;
    logic [scr_w-1:0]    scr2_pxl;
    logic [obj_w-1:0]    obj_pxl;
    logic                hblank_n;
    logic                vblank_n;
    logic                cpu_req;
    logic                cpu_we;
    logic [pal_aw-1:0]   cpu_addr;
    logic [pal_dw-1:0]   cpu_wdata;
    logic [pal_bw-1:0]   cpu_be;
    logic                cpu_ack;
    logic [pal_dw-1:0]   cpu_rdata;
    logic [col_w-1:0]    red;
    logic [col_w-1:0]    green;
    logic [col_w-1:0]    blue;
    logic                hblank_dly_n;
    logic                vblank_dly_n;

    logic [31:0]         lfsr;
    logic                cen_run;
    logic                check_rgb;
    logic                ven_prev;
    int                  mismatches;
    int                  timeouts;
    // palette as the cpu wrote it
    logic [pal_dw-1:0]   pal_model [pal_depth];
    // {check rgb, hblank_n, vblank_n, rgb} per strobe
    logic [17:0]         exp_q [$];

    colmix_top UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .pxl_cen      (pxl_cen),
        .video_en     (video_en),
        .gfx_en       (gfx_en),
        .char_pxl     (char_pxl),
        .scr1_pxl     (scr1_pxl),
        .scr2_pxl     (scr2_pxl),
        .obj_pxl      (obj_pxl),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .cpu_req      (cpu_req),
        .cpu_we       (cpu_we),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_be       (cpu_be),
        .cpu_ack      (cpu_ack),
        .cpu_rdata    (cpu_rdata),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // pixel enable on every second clk once started
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            pxl_cen <= cen_run && !pxl_cen;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // visible colour of one pixel as {shadow, object half, palette, colour}
    function automatic logic [pal_aw:0] pick_colour(
        input logic [n_layers-1:0] en,
        input logic [char_w-1:0]   ch,
        input logic [scr_w-1:0]    s1,
        input logic [scr_w-1:0]    s2,
        input logic [obj_w-1:0]    ob
    );
        logic [9:0]      tile  [4];
        logic            tprio [4];
        logic [1:0]      need  [4];
        logic [pal_aw:0] pick  [4];
        logic [pal_aw:0] res;
        logic            found;
        if (!en[0]) ch[3:0] = 4'd0;
        if (!en[1]) s1[3:0] = 4'd0;
        if (!en[2]) s2[3:0] = 4'd0;
        if (!en[3]) ob[3:0] = 4'd0;
        tile[0] = {4'd0, ch[5:0]};
        tprio[0] = ch[6];
        need[0] = 2'd3;
        tile[1] = s1[9:0];
        tprio[1] = s1[10];
        need[1] = 2'd2;
        tile[2] = s2[9:0];
        tprio[2] = s2[10];
        need[2] = 2'd1;
        // backdrop, colourless scroll 2, loses to any object
        tile[3] = {s2[9:4], 4'd0};
        tprio[3] = 1'b0;
        need[3] = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (ob[3:0] != 4'd0 && ob[11:10] >= need[i] &&
                (!tprio[i] || tile[i][2:0] == 3'd0)) begin
                if (ob[9:4] == shadow_pal) pick[i] = {2'b10, tile[i]};
                else pick[i] = {2'b01, ob[9:0]};
            end else begin
                pick[i] = {2'b00, tile[i]};
            end
        end
        res = pick[3];
        found = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (!found && (pick[i][pal_aw-1] ? pick[i][3:0] != 4'd0
                                              : pick[i][2:0] != 3'd0)) begin
                res = pick[i];
                found = 1'b1;
            end
        end
        return res;
    endfunction

    function automatic logic [rgb_w-1:0] expected_rgb(input logic [pal_aw:0] sel);
        logic [pal_dw-1:0] w;
        logic [col_w-1:0]  c [3];
        w = pal_model[sel[pal_aw-1:0]];
        c[0] = {w[3:0], w[12]};
        c[1] = {w[7:4], w[13]};
        c[2] = {w[11:8], w[14]};
        // shadow dims to three quarters unless bit 15 protects the colour
        if (sel[pal_aw] && !w[15]) begin
            for (int i = 0; i < 3; i++) c[i] = c[i] - (c[i] >> 2);
        end
        return {c[0], c[1], c[2]};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Fail t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // one strobe of the model, run at the strobe edge before new inputs are driven
    task automatic model_step;
        logic [17:0]      e;
        logic [rgb_w-1:0] c;
        if (exp_q.size() == pipe_dly) begin
            e = exp_q.pop_front();
            check("hblank_dly_n", 32'(hblank_dly_n), 32'(e[16]));
            check("vblank_dly_n", 32'(vblank_dly_n), 32'(e[15]));
            // video_en acts in the last stage, one strobe before these outputs
            c = ven_prev ? e[14:0] : '0;
            if (e[17]) begin
                check("red", 32'(red), 32'(c[14:10]));
                check("green", 32'(green), 32'(c[9:5]));
                check("blue", 32'(blue), 32'(c[4:0]));
            end
        end
        exp_q.push_back({check_rgb, hblank_n, vblank_n,
                         expected_rgb(pick_colour(gfx_en, char_pxl, scr1_pxl, scr2_pxl, obj_pxl))});
        ven_prev = video_en;
    endtask

    task automatic next_strobe;
        int waited;
        waited = 0;
        @(posedge clk);
        while (!pxl_cen && waited < cen_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (!pxl_cen) begin
            timeouts++;
            $display("timeout: pxl_cen did not pulse at %0t", $time);
        end else begin
            model_step();
        end
    endtask

    task automatic run_pixels(input int n, input int mode);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            next_strobe();
            r = rand_bits(char_w);
            char_pxl <= r[char_w-1:0];
            r = rand_bits(scr_w);
            scr1_pxl <= r[scr_w-1:0];
            r = rand_bits(scr_w);
            scr2_pxl <= r[scr_w-1:0];
            r = rand_bits(obj_w);
            if (mode == mode_shadow) begin
                r[9:4] = shadow_pal;
                if (r[3:0] == 4'd0) r[0] = 1'b1;
            end
            obj_pxl <= r[obj_w-1:0];
            r = rand_bits(2);
            hblank_n <= r[0];
            vblank_n <= r[1];
            if (mode == mode_gate) begin
                r = rand_bits(n_layers + 1);
                gfx_en   <= r[n_layers-1:0];
                video_en <= r[n_layers];
            end
        end
    endtask

    // four-phase access, ack expected 3 edges after req is driven, release 1 edge after drop
    task automatic cpu_access(input logic we, input logic [pal_aw-1:0] addr,
                              input logic [pal_dw-1:0] data, input logic [pal_bw-1:0] be);
        int   waited;
        logic acked;
        check("cpu_ack before req", 32'(cpu_ack), 32'd0);
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_we    <= we;
        cpu_addr  <= addr;
        cpu_wdata <= data;
        cpu_be    <= be;
        @(negedge clk);
        waited = 0;
        while (!cpu_ack && waited < hs_timeout) begin
            @(negedge clk);
            waited++;
        end
        acked = cpu_ack;
        if (!acked) begin
            timeouts++;
            $display("timeout: no cpu_ack for address %0h", addr);
        end else begin
            check("cpu_ack delay", 32'(waited), 32'd3);
            if (!we) check("cpu_rdata", 32'(cpu_rdata), 32'(pal_model[addr]));
        end
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        if (acked) begin
            check("cpu_ack hold", 32'(cpu_ack), 32'd1);
            waited = 0;
            while (cpu_ack && waited < hs_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (cpu_ack) begin
                timeouts++;
                $display("timeout: cpu_ack stuck high for address %0h", addr);
            end else begin
                check("cpu_ack release", 32'(waited), 32'd1);
            end
        end
    endtask

    task automatic cpu_write(input logic [pal_aw-1:0] addr, input logic [pal_dw-1:0] data,
                             input logic [pal_bw-1:0] be);
        for (int b = 0; b < pal_bw; b++) begin
            if (be[b]) pal_model[addr][b*8 +: 8] = data[b*8 +: 8];
        end
        cpu_access(1'b1, addr, data, be);
    endtask

    task automatic end_run(input logic timed_out);
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts + int'(timed_out));
        if (mismatches == 0 && timeouts == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // whole-run limit
    initial begin
        #400us;
        $display("timeout: simulation did not finish in time");
        end_run(1'b1);
    end

    initial begin
        logic [31:0]       r;
        logic [pal_aw-1:0] addr_list [$];
        arst_n = 1'b0;
        video_en = 1'b1;
        gfx_en = '1;
        char_pxl = '0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        obj_pxl = '0;
        hblank_n = 1'b1;
        vblank_n = 1'b1;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_be = '0;
        lfsr = seed;
        cen_run = 1'b0;
        check_rgb = 1'b1;
        ven_prev = 1'b0;
        mismatches = 0;
        timeouts = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // reset state, no pxl_cen yet
        repeat (3) @(negedge clk);
        check("red after reset", 32'(red), 32'd0);
        check("green after reset", 32'(green), 32'd0);
        check("blue after reset", 32'(blue), 32'd0);
        check("hblank_dly_n after reset", 32'(hblank_dly_n), 32'd0);
        check("vblank_dly_n after reset", 32'(vblank_dly_n), 32'd0);
        check("cpu_ack after reset", 32'(cpu_ack), 32'd0);

        // full palette fill, then partial writes and read-back
        for (int a = 0; a < pal_depth; a++) begin
            r = rand_bits(pal_dw);
            cpu_write(a[pal_aw-1:0], r[pal_dw-1:0], '1);
        end
        for (int i = 0; i < 40; i++) begin
            r = rand_bits(pal_aw + pal_dw + pal_bw);
            addr_list.push_back(r[pal_aw-1:0]);
            cpu_write(r[pal_aw-1:0], r[pal_aw +: pal_dw], r[pal_aw + pal_dw +: pal_bw]);
        end
        foreach (addr_list[i]) begin
            cpu_access(1'b0, addr_list[i], '0, '0);
        end

        // pixel path: priority, shadow, gating
        cen_run = 1'b1;
        run_pixels(400, mode_mix);
        run_pixels(200, mode_shadow);
        run_pixels(300, mode_gate);
        gfx_en <= '1;
        video_en <= 1'b1;
        run_pixels(pipe_dly + 4, mode_mix);

        // blanks while the cpu rewrites palette entries
        check_rgb = 1'b0;
        fork
            run_pixels(150, mode_mix);
            begin
                for (int i = 0; i < 12; i++) begin
                    r = rand_bits(pal_aw + pal_dw);
                    cpu_write(r[pal_aw-1:0], r[pal_aw +: pal_dw], '1);
                end
            end
        join
        check_rgb = 1'b1;
        run_pixels(100, mode_mix);
        end_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== colmix_top.sv ====
// colour mixer top level
// layer_prio -> pal_ram -> video_out, cpu palette access through req/ack
// blanks and shadow delayed here to meet the palette stage
`timescale 1ns/100ps
`default_nettype none

module colmix_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            pxl_cen,
    input  logic                            video_en,
    input  logic [colmix_pkg::n_layers-1:0] gfx_en,
    input  logic [colmix_pkg::char_w-1:0]   char_pxl,
    input  logic [colmix_pkg::scr_w-1:0]    scr1_pxl,
    input  logic [colmix_pkg::scr_w-1:0]    scr2_pxl,
    input  logic [colmix_pkg::obj_w-1:0]    obj_pxl,
    input  logic                            hblank_n,
    input  logic                            vblank_n,
    // cpu palette port
    input  logic                            cpu_req,
    input  logic                            cpu_we,
    input  logic [colmix_pkg::pal_aw-1:0]   cpu_addr,
    input  logic [colmix_pkg::pal_dw-1:0]   cpu_wdata,
    input  logic [colmix_pkg::pal_bw-1:0]   cpu_be,
    output logic                            cpu_ack,
    output logic [colmix_pkg::pal_dw-1:0]   cpu_rdata,
    // video out
    output logic [colmix_pkg::col_w-1:0]    red,
    output logic [colmix_pkg::col_w-1:0]    green,
    output logic [colmix_pkg::col_w-1:0]    blue,
    output logic                            hblank_dly_n,
    output logic                            vblank_dly_n
);
    import colmix_pkg::*;

    logic [pal_aw-1:0]   pal_addr;
    logic                shadow;
    logic                shadow_q;
    logic [pal_dw-1:0]   pal_data;
    logic [pal_aw-1:0]   ram_addr;
    logic [pal_bw-1:0]   ram_we;
    logic [pal_dw-1:0]   ram_wdata;
    logic [pal_dw-1:0]   ram_rdata;
    // blank delay, last stage lives in video_out
    logic [pipe_dly-2:0] hb_sr;
    logic [pipe_dly-2:0] vb_sr;

    layer_prio u_prio (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_addr (pal_addr),
        .shadow   (shadow)
    );

    pal_cpu_port u_cpu (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_be    (cpu_be),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    pal_ram u_ram (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .cpu_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    // shadow one strobe behind layer_prio, next to pal_data
    // blanks two strobes, video_out adds the third
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shadow_q <= 1'b0;
            hb_sr    <= '0;
            vb_sr    <= '0;
        end else if (pxl_cen) begin
            shadow_q <= shadow;
            hb_sr    <= {hb_sr[pipe_dly-3:0], hblank_n};
            vb_sr    <= {vb_sr[pipe_dly-3:0], vblank_n};
        end
    end

    video_out u_out (
        .clk          (clk),
        .arst_n       (arst_n),
        .pxl_cen      (pxl_cen),
        .video_en     (video_en),
        .shadow       (shadow_q),
        .pal_data     (pal_data),
        .hblank_n     (hb_sr[pipe_dly-2]),
        .vblank_n     (vb_sr[pipe_dly-2]),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n)
    );

endmodule

`default_nettype wire

// ==== video_out.sv ====
// last pixel stage
// unpacks the palette word, dims shadowed pixels, applies video enable
// rgb and blanks registered together on pxl_cen
`timescale 1ns/100ps
`default_nettype none

module video_out (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            pxl_cen,
    input  logic                            video_en,
    input  logic                            shadow,
    input  logic [colmix_pkg::pal_dw-1:0]   pal_data,
    input  logic                            hblank_n,
    input  logic                            vblank_n,
    output logic [colmix_pkg::col_w-1:0]    red,
    output logic [colmix_pkg::col_w-1:0]    green,
    output logic [colmix_pkg::col_w-1:0]    blue,
    output logic                            hblank_dly_n,
    output logic                            vblank_dly_n
);
    import colmix_pkg::*;

    // roughly 75 percent brightness
    function automatic logic [col_w-1:0] dim(input logic [col_w-1:0] c);
        return c - (c >> 2);
    endfunction

    logic [col_w-1:0] r_pal;
    logic [col_w-1:0] g_pal;
    logic [col_w-1:0] b_pal;
    logic [rgb_w-1:0] gated;
    logic [rgb_w-1:0] rgb_q;

    // palette word: four upper bits per channel in [11:0], lsbs in [14:12]
    assign r_pal = {pal_data[3:0],  pal_data[12]};
    assign g_pal = {pal_data[7:4],  pal_data[13]};
    assign b_pal = {pal_data[11:8], pal_data[14]};

    always_comb begin
        // bit 15 set means colour ignores shadow
        if (shadow && !pal_data[15]) begin
            gated = {dim(r_pal), dim(g_pal), dim(b_pal)};
        end else begin
            gated = {r_pal, g_pal, b_pal};
        end
        if (!video_en) begin
            gated = '0;
        end
    end

    // blanks start low so the screen reads as blanked after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb_q        <= '0;
            hblank_dly_n <= 1'b0;
            vblank_dly_n <= 1'b0;
        end else if (pxl_cen) begin
            rgb_q        <= gated;
            hblank_dly_n <= hblank_n;
            vblank_dly_n <= vblank_n;
        end
    end

    assign {red, green, blue} = rgb_q;

endmodule

`default_nettype wire

// ==== pal_cpu_port.sv ====
// four-phase req/ack slave for palette access
// one ram access per request; ack 2 clk after req, released 1 clk after req drops
`timescale 1ns/100ps
`default_nettype none

module pal_cpu_port (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            cpu_req,
    input  logic                            cpu_we,
    input  logic [colmix_pkg::pal_aw-1:0]   cpu_addr,
    input  logic [colmix_pkg::pal_dw-1:0]   cpu_wdata,
    input  logic [colmix_pkg::pal_bw-1:0]   cpu_be,
    output logic                            cpu_ack,
    output logic [colmix_pkg::pal_dw-1:0]   cpu_rdata,
    // palette side
    output logic [colmix_pkg::pal_aw-1:0]   ram_addr,
    output logic [colmix_pkg::pal_bw-1:0]   ram_we,
    output logic [colmix_pkg::pal_dw-1:0]   ram_wdata,
    input  logic [colmix_pkg::pal_dw-1:0]   ram_rdata
);
    import colmix_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_ack,
        st_release
    } state_t;

    state_t            state;
    logic              we_q;
    logic [pal_bw-1:0] be_q;

    // request fields latched at the start of each access
    always_ff @(posedge clk) begin
        if (state == st_idle && cpu_req) begin
            ram_addr  <= cpu_addr;
            ram_wdata <= cpu_wdata;
            be_q      <= cpu_be;
            we_q      <= cpu_we;
        end
    end

    // write strobe only in the access cycle
    assign ram_we = (state == st_access && we_q) ? be_q : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            cpu_ack <= 1'b0;
        end else begin
            case (state)
                st_idle:    if (cpu_req) state <= st_access;
                // ram read data lands at the end of this cycle
                st_access:  state <= st_ack;
                st_ack: begin
                    cpu_ack <= 1'b1;
                    state   <= st_release;
                end
                // wait for master to drop req
                st_release: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default:    state <= st_idle;
            endcase
        end
    end

    // read data held until next request reaches ack
    always_ff @(posedge clk) begin
        if (state == st_ack) begin
            cpu_rdata <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== pal_ram.sv ====
// dual-port palette memory
// video side reads on pxl_cen, cpu side writes bytes and reads every clk
`timescale 1ns/100ps
`default_nettype none

module pal_ram (
    input  logic                            clk,
    input  logic                            pxl_cen,
    // video port
    input  logic [colmix_pkg::pal_aw-1:0]   pal_addr,
    output logic [colmix_pkg::pal_dw-1:0]   pal_data,
    // cpu port
    input  logic [colmix_pkg::pal_aw-1:0]   cpu_addr,
    input  logic [colmix_pkg::pal_bw-1:0]   ram_we,
    input  logic [colmix_pkg::pal_dw-1:0]   ram_wdata,
    output logic [colmix_pkg::pal_dw-1:0]   ram_rdata
);
    import colmix_pkg::*;

    // palette words, contents come only from cpu writes
    logic [pal_dw-1:0] mem [pal_depth];

    // cpu side
    // byte lanes written separately, read is registered
    always_ff @(posedge clk) begin
        for (int b = 0; b < pal_bw; b++) begin
            if (ram_we[b]) begin
                mem[cpu_addr][b*8 +: 8] <= ram_wdata[b*8 +: 8];
            end
        end
        ram_rdata <= mem[cpu_addr];
    end

    // video side
    // one read per pixel, old data on a same-cycle cpu write
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_data <= mem[pal_addr];
        end
    end

endmodule

`default_nettype wire

// ==== layer_prio.sv ====
// first pixel stage of the mixer
// gates layers, resolves tile against object and registers the palette address
// a shadow object shows the tile below with the shadow flag set
`timescale 1ns/100ps
`default_nettype none

module layer_prio (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              pxl_cen,
    input  logic [colmix_pkg::n_layers-1:0]   gfx_en,
    input  logic [colmix_pkg::char_w-1:0]     char_pxl,
    input  logic [colmix_pkg::scr_w-1:0]      scr1_pxl,
    input  logic [colmix_pkg::scr_w-1:0]      scr2_pxl,
    input  logic [colmix_pkg::obj_w-1:0]      obj_pxl,
    output logic [colmix_pkg::pal_aw-1:0]     pal_addr,
    output logic                              shadow
);
    import colmix_pkg::*;

    // candidate layout
    // [pal_aw] shadow, [pal_aw-1] object half, [pal_aw-2:0] palette and colour
    function automatic logic [pal_aw:0] tile_or_obj(
        input logic [pal_aw-2:0] obj,
        input logic [pal_aw-2:0] tile,
        input logic              tile_prio,
        input logic              obj_ok
    );
        logic obj_wins;
        // object needs a colour, the priority slot and a weak or clear tile
        obj_wins = (obj[3:0] != 4'd0) && obj_ok && (!tile_prio || tile[2:0] == 3'd0);
        if (!obj_wins) begin
            tile_or_obj = {2'b00, tile};
        end else if (obj[pal_aw-2:4] == shadow_pal) begin
            // shadow sprite, keep tile and mark it
            tile_or_obj = {2'b10, tile};
        end else begin
            tile_or_obj = {2'b01, obj};
        end
    endfunction

    // objects are opaque on all four colour bits, tiles only on the low three
    function automatic logic is_opaque(input logic [pal_aw:0] cand);
        logic res;
        if (cand[pal_aw-1]) begin
            res = cand[3:0] != 4'd0;
        end else begin
            res = cand[2:0] != 3'd0;
        end
        return res;
    endfunction

    logic [char_w-1:0] char_g;
    logic [scr_w-1:0]  scr1_g;
    logic [scr_w-1:0]  scr2_g;
    logic [obj_w-1:0]  obj_g;
    logic [1:0]        obj_prio;
    logic [pal_aw:0]   cand [n_layers];
    logic [pal_aw:0]   chosen;

    // layer gating, a disabled layer loses its colour bits only
    always_comb begin
        char_g = char_pxl;
        scr1_g = scr1_pxl;
        scr2_g = scr2_pxl;
        obj_g  = obj_pxl;
        if (!gfx_en[0]) char_g[3:0] = 4'd0;
        if (!gfx_en[1]) scr1_g[3:0] = 4'd0;
        if (!gfx_en[2]) scr2_g[3:0] = 4'd0;
        if (!gfx_en[3]) obj_g[3:0]  = 4'd0;
    end

    assign obj_prio = obj_g[obj_w-1 -: 2];

    // char sits on palette 0 of the tile half
    assign cand[0] = tile_or_obj(obj_g[pal_aw-2:0], {4'd0, char_g[char_w-2:0]},
                                 char_g[char_w-1], obj_prio == 2'd3);
    assign cand[1] = tile_or_obj(obj_g[pal_aw-2:0], scr1_g[pal_aw-2:0],
                                 scr1_g[scr_w-1], obj_prio >= 2'd2);
    assign cand[2] = tile_or_obj(obj_g[pal_aw-2:0], scr2_g[pal_aw-2:0],
                                 scr2_g[scr_w-1], obj_prio >= 2'd1);
    // backdrop, scroll 2 palette with no colour, any visible object beats it
    assign cand[3] = tile_or_obj(obj_g[pal_aw-2:0], {scr2_g[pal_aw-2:4], 4'd0},
                                 1'b0, 1'b1);

    // first opaque candidate wins, backdrop otherwise
    always_comb begin
        chosen = cand[n_layers-1];
        for (int i = n_layers - 2; i >= 0; i--) begin
            if (is_opaque(cand[i])) begin
                chosen = cand[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pal_addr <= '0;
            shadow   <= 1'b0;
        end else if (pxl_cen) begin
            pal_addr <= chosen[pal_aw-1:0];
            shadow   <= chosen[pal_aw];
        end
    end

endmodule

`default_nettype wire

// ==== colmix_pkg.sv ====
// shared widths and constants for the colour mixer
// imported by every stage; pixel field layouts are noted next to each width
`default_nettype none

package colmix_pkg;

    // character pixel: [6] tile priority, [5:0] colour
    localparam int char_w = 7;

    // scroll pixel: [10] priority, [9:4] palette, [3:0] colour
    localparam int scr_w = 11;

    // object pixel: [11:10] priority, [9:4] palette, [3:0] colour
    localparam int obj_w = 12;

    // palette geometry
    // address bit 10 selects the object half
    localparam int pal_aw    = 11;
    localparam int pal_dw    = 16;
    localparam int pal_depth = 1 << pal_aw;
    // one write enable per byte
    localparam int pal_bw    = pal_dw / 8;

    // output colour
    localparam int col_w = 5;
    localparam int rgb_w = 3 * col_w;

    // char, scroll 1, scroll 2, object
    // also the gfx_en width
    localparam int n_layers = 4;

    // object palette that darkens the tile below instead of drawing
    localparam logic [5:0] shadow_pal = 6'h3f;

    // pixel pipeline depth in pxl_cen strobes
    // layer_prio, palette read, video_out
    localparam int pipe_dly = 3;

endpackage

`default_nettype wire
